// File: addressRegs.sv
`timescale 1ns/1ns

module addressRegs
	import datapathPkg::*;
	import isaPkg::*;
#(
	parameter wordT resetPc = '0
) (
	input logic clock,
	input logic rstN,
	input wordT busValue,
	input logic pcIn,
	input logic incPc,
	input logic irIn,
	input logic marIn,
	output wordT pcWord,
	output instrWordT irWord,
	output wordT marValue
);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			pcWord <= resetPc;
			irWord <= '0;
			marValue <= '0;
		end else begin
			// jump target from the bus, otherwise step by one
			if (pcIn) begin
				pcWord <= busValue;
			end else if (incPc) begin
				pcWord <= pcWord + 1'b1;
			end
			if (irIn) begin
				irWord <= busValue;
			end
			if (marIn) begin
				marValue <= busValue;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstN) !(pcIn && incPc))
	else
		$error("addressRegs: PC load and increment in the same step");

endmodule

// File: aluUnit.sv
`timescale 1ns/1ns

module aluUnit
	import datapathPkg::*;
	import isaPkg::*;
(
	input logic clock,
	input logic rstN,
	input instrWordT irWord,
	input wordT busValue,
	input logic yIn,
	input logic zIn,
	input logic hiIn,
	input logic loIn,
	output wordT zHighWord,
	output wordT zLowWord,
	output wordT hiWord,
	output wordT loWord
);

	wordT yReg;
	wordT lowResult;
	logic [4:0] shiftAmount;
	dwordT product;
	dwordT aluResult;

	assign shiftAmount = busValue[4:0];

	// low 64 bits of the sign-extended operands give the signed product
	assign product = {{wordWidth{yReg[wordWidth-1]}}, yReg} *
		{{wordWidth{busValue[wordWidth-1]}}, busValue};

	// A is Y, B is the bus; neg and not act on B alone
	always_comb begin
		case (irWord.rFmt.opcode)
			opAdd, opAddi: lowResult = yReg + busValue;
			opSub: lowResult = yReg - busValue;
			opAnd: lowResult = yReg & busValue;
			opOr: lowResult = yReg | busValue;
			opShl: lowResult = yReg << shiftAmount;
			// logical shift, zero fill
			opShr: lowResult = yReg >> shiftAmount;
			opRol: lowResult = (yReg << shiftAmount) | (yReg >> (6'd32 - shiftAmount));
			opRor: lowResult = (yReg >> shiftAmount) | (yReg << (6'd32 - shiftAmount));
			opNeg: lowResult = -busValue;
			opNot: lowResult = ~busValue;
			default: lowResult = '0;
		endcase
	end

	assign aluResult = (irWord.rFmt.opcode == opMul) ? product :
		{{wordWidth{lowResult[wordWidth-1]}}, lowResult};

	always_ff @(posedge clock) begin
		if (!rstN) begin
			yReg <= '0;
			zHighWord <= '0;
			zLowWord <= '0;
			hiWord <= '0;
			loWord <= '0;
		end else begin
			if (yIn) begin
				yReg <= busValue;
			end
			// both halves of Z load together
			if (zIn) begin
				{zHighWord, zLowWord} <= aluResult;
			end
			if (hiIn) begin
				hiWord <= busValue;
			end
			if (loIn) begin
				loWord <= busValue;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstN)
		zIn |-> irWord.rFmt.opcode inside {opAdd, opSub, opAnd, opOr, opShl, opShr,
			opRol, opRor, opNeg, opNot, opMul, opAddi})
	else
		$error("aluUnit: Z loaded under an undefined opcode");

endmodule

// File: busMux.sv
`timescale 1ns/1ns

module busMux
	import datapathPkg::*;
	import isaPkg::*;
(
	input wordT regWord,
	input wordT cWord,
	input wordT pcWord,
	input instrWordT irWord,
	input wordT mdrWord,
	input wordT inPortWord,
	input wordT hiWord,
	input wordT loWord,
	input wordT zHighWord,
	input wordT zLowWord,
	input logic rOut,
	input logic cOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inPortOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	output wordT busValue
);

	// masked OR of all sources, idle bus reads zero
	assign busValue = ({wordWidth{rOut}} & regWord)
		| ({wordWidth{cOut}} & cWord)
		| ({wordWidth{pcOut}} & pcWord)
		| ({wordWidth{mdrOut}} & mdrWord)
		| ({wordWidth{inPortOut}} & inPortWord)
		| ({wordWidth{hiOut}} & hiWord)
		| ({wordWidth{loOut}} & loWord)
		| ({wordWidth{zHighOut}} & zHighWord)
		| ({wordWidth{zLowOut}} & zLowWord);

	// no clock here, so the checks are immediate
	always_comb begin
		assert ($onehot0({rOut, cOut, pcOut, mdrOut, inPortOut, hiOut, loOut,
			zHighOut, zLowOut}))
		else
			$error("busMux: more than one source driving the bus");
		// the constant is only meaningful under the immediate format
		if (cOut) begin
			assert (irWord.iFmt.opcode == opAddi)
			else
				$error("busMux: constant driven without an I-format instruction");
		end
	end

endmodule

// File: dataPath.sv
`timescale 1ns/1ns

module dataPath
	import datapathPkg::*;
	import isaPkg::*;
#(
	parameter wordT resetPc = '0
) (
	input logic clock,
	input logic rstN,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	input logic pcIn,
	input logic pcOut,
	input logic incPc,
	input logic irIn,
	input logic marIn,
	input logic mdrIn,
	input logic mdrOut,
	input logic mdRead,
	input logic yIn,
	input logic zIn,
	input logic zHighOut,
	input logic zLowOut,
	input logic hiIn,
	input logic hiOut,
	input logic loIn,
	input logic loOut,
	input logic cOut,
	input logic inPortOut,
	input logic strobe,
	input logic outPortIn,
	input wordT memDataIn,
	input wordT inPortData,
	output wordT busValue,
	output wordT outPortData,
	output wordT marValue
);

	wordT regWord;
	wordT cWord;
	wordT pcWord;
	wordT mdrWord;
	wordT inPortWord;
	wordT hiWord;
	wordT loWord;
	wordT zHighWord;
	wordT zLowWord;
	instrWordT irWord;

	regSelectIf sel ();

	// register select strobes come straight from the pins
	assign sel.gra = gra;
	assign sel.grb = grb;
	assign sel.grc = grc;
	assign sel.rIn = rIn;
	assign sel.rOut = rOut;
	assign sel.baOut = baOut;

	regFile regs (
		.clock(clock),
		.rstN(rstN),
		.sel(sel.regs),
		.irWord(irWord),
		.busValue(busValue),
		.regWord(regWord),
		.cWord(cWord)
	);

	aluUnit alu (
		.clock(clock),
		.rstN(rstN),
		.irWord(irWord),
		.busValue(busValue),
		.yIn(yIn),
		.zIn(zIn),
		.hiIn(hiIn),
		.loIn(loIn),
		.zHighWord(zHighWord),
		.zLowWord(zLowWord),
		.hiWord(hiWord),
		.loWord(loWord)
	);

	busMux bus (
		.regWord(regWord),
		.cWord(cWord),
		.pcWord(pcWord),
		.irWord(irWord),
		.mdrWord(mdrWord),
		.inPortWord(inPortWord),
		.hiWord(hiWord),
		.loWord(loWord),
		.zHighWord(zHighWord),
		.zLowWord(zLowWord),
		.rOut(rOut),
		.cOut(cOut),
		.pcOut(pcOut),
		.mdrOut(mdrOut),
		.inPortOut(inPortOut),
		.hiOut(hiOut),
		.loOut(loOut),
		.zHighOut(zHighOut),
		.zLowOut(zLowOut),
		.busValue(busValue)
	);

	portRegs ports (
		.clock(clock),
		.rstN(rstN),
		.busValue(busValue),
		.memDataIn(memDataIn),
		.inPortData(inPortData),
		.mdrIn(mdrIn),
		.mdRead(mdRead),
		.strobe(strobe),
		.outPortIn(outPortIn),
		.mdrWord(mdrWord),
		.inPortWord(inPortWord),
		.outPortData(outPortData)
	);

	addressRegs #(
		.resetPc(resetPc)
	) addrs (
		.clock(clock),
		.rstN(rstN),
		.busValue(busValue),
		.pcIn(pcIn),
		.incPc(incPc),
		.irIn(irIn),
		.marIn(marIn),
		.pcWord(pcWord),
		.irWord(irWord),
		.marValue(marValue)
	);

endmodule

// File: datapathPkg.sv
package datapathPkg;

	localparam int wordWidth = 32;
	localparam int regCount = 16;

	// bus and register word
	typedef logic [wordWidth-1:0] wordT;

	// full multiplier product
	typedef logic [2*wordWidth-1:0] dwordT;

	// general register number
	typedef logic [$clog2(regCount)-1:0] regIndexT;

endpackage

// File: isaPkg.sv
package isaPkg;

	localparam int instrWidth = 32;
	localparam int opcodeWidth = 5;
	localparam int regFieldWidth = 4;
	localparam int constWidth = 18;
	// R-format pads below rc, I-format has one spare bit above the constant
	localparam int rUnusedWidth = instrWidth - opcodeWidth - 3 * regFieldWidth;
	localparam int iSpareWidth = instrWidth - opcodeWidth - 2 * regFieldWidth - constWidth;

	// opcode numbering follows the full instruction set, so there are gaps
	typedef enum logic [opcodeWidth-1:0] {
		opAdd  = 5'b00011,
		opSub  = 5'b00100,
		opShr  = 5'b00101,
		opShl  = 5'b00110,
		opRor  = 5'b00111,
		opRol  = 5'b01000,
		opAnd  = 5'b01001,
		opOr   = 5'b01010,
		opAddi = 5'b01011,
		opMul  = 5'b01110,
		opNeg  = 5'b10000,
		opNot  = 5'b10001
	} opcodeT;

	typedef struct packed {
		opcodeT opcode;
		logic [regFieldWidth-1:0] ra;
		logic [regFieldWidth-1:0] rb;
		logic [regFieldWidth-1:0] rc;
		logic [rUnusedWidth-1:0] unused;
	} rFormatT;

	typedef struct packed {
		opcodeT opcode;
		logic [regFieldWidth-1:0] ra;
		logic [regFieldWidth-1:0] rb;
		logic [iSpareWidth-1:0] spare;
		logic [constWidth-1:0] constant;
	} iFormatT;

	// one IR word, read either as three registers or as register plus constant
	typedef union packed {
		rFormatT rFmt;
		iFormatT iFmt;
	} instrWordT;

endpackage

// File: portRegs.sv
`timescale 1ns/1ns

module portRegs
	import datapathPkg::*;
(
	input logic clock,
	input logic rstN,
	input wordT busValue,
	input wordT memDataIn,
	input wordT inPortData,
	input logic mdrIn,
	input logic mdRead,
	input logic strobe,
	input logic outPortIn,
	output wordT mdrWord,
	output wordT inPortWord,
	output wordT outPortData
);

	wordT mdrNext;

	// memory read takes priority over the bus
	assign mdrNext = mdRead ? memDataIn : busValue;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			mdrWord <= '0;
			inPortWord <= '0;
			outPortData <= '0;
		end else begin
			if (mdrIn) begin
				mdrWord <= mdrNext;
			end
			// external device presents data with strobe
			if (strobe) begin
				inPortWord <= inPortData;
			end
			if (outPortIn) begin
				outPortData <= busValue;
			end
		end
	end

endmodule

// File: project.f
isaPkg.sv
datapathPkg.sv
regSelectIf.sv
regFile.sv
aluUnit.sv
busMux.sv
portRegs.sv
addressRegs.sv
dataPath.sv
tbChecker.sv
tbDataPath.sv

// File: regFile.sv
`timescale 1ns/1ns

module regFile
	import datapathPkg::*;
	import isaPkg::*;
(
	input logic clock,
	input logic rstN,
	regSelectIf.regs sel,
	input instrWordT irWord,
	input wordT busValue,
	output wordT regWord,
	output wordT cWord
);

	wordT regs [regCount];
	regIndexT regSel;
	logic selValid;
	logic zeroBase;

	// field select, ra wins over rb over rc
	always_comb begin
		regSel = '0;
		if (sel.gra) begin
			regSel = irWord.rFmt.ra;
		end else if (sel.grb) begin
			regSel = irWord.rFmt.rb;
		end else if (sel.grc) begin
			regSel = irWord.rFmt.rc;
		end
	end

	assign selValid = sel.gra | sel.grb | sel.grc;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (sel.rIn && selValid) begin
			regs[regSel] <= busValue;
		end
	end

	// R0 as base address means no base
	assign zeroBase = sel.baOut && (regSel == '0);

	assign regWord = (sel.rOut && selValid && !zeroBase) ? regs[regSel] : '0;

	// 18-bit constant, sign extended to a full word
	assign cWord = {{(wordWidth - constWidth){irWord.iFmt.constant[constWidth-1]}},
		irWord.iFmt.constant};

	// the decoder can only honour one field at a time
	assert property (@(posedge clock) disable iff (!rstN)
		$onehot0({sel.gra, sel.grb, sel.grc}))
	else
		$error("regFile: more than one register field selected");

endmodule

// File: regSelectIf.sv
`timescale 1ns/1ns

interface regSelectIf;

	// which IR field names the register
	logic gra;
	logic grb;
	logic grc;

	// load and drive strobes for the chosen register
	logic rIn;
	logic rOut;

	// base address use, R0 reads as zero
	logic baOut;

	modport ctrl (output gra, grb, grc, rIn, rOut, baOut);

	modport regs (input gra, grb, grc, rIn, rOut, baOut);

endinterface

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tbDataPath -f project.f -o simDataPath
./obj_dir/simDataPath > sim.log
cat sim.log
if grep -q ">>> PASS" sim.log; then
	exit 0
fi
exit 1

// File: stepsInput.dat
# name, strobe mask (bit 0 gra .. bit 25 outPortIn), memDataIn, inPortData,
# expected busValue, expected outPortData
rstIdle 0 0 0 00000000 00000000
rstPc 80 0 0 00000040 00000000
irMdr 2800 18918000 0 00000000 00000000
irLoad 3A00 5A5A1234 0 18918000 00000000
r1Load 3809 92345678 0 5A5A1234 00000000
r2Load 380A 00000104 0 92345678 00000000
r3Load 100C 0 0 00000104 00000000
r1Read 11 0 0 5A5A1234 00000000
r2ReadY 4012 0 0 92345678 00000000
r3ReadZ 8014 0 0 00000104 00000000
addLow 22800 20918000 0 9234577C 00000000
addHigh 10000 0 0 FFFFFFFF 00000000
subIr 1200 0 0 20918000 00000000
subZ 8014 0 0 00000104 00000000
subLow 22800 48918000 0 92345574 00000000
andIr 1200 0 0 48918000 00000000
andZ 8014 0 0 00000104 00000000
andLow 22800 50918000 0 00000000 00000000
orIr 1200 0 0 50918000 00000000
orZ 8014 0 0 00000104 00000000
orLow 22800 30918000 0 9234577C 00000000
shlIr 1200 0 0 30918000 00000000
shlZ 8014 0 0 00000104 00000000
shlLow 22800 28918000 0 23456780 00000000
shlHigh 10000 0 0 00000000 00000000
shrIr 1200 0 0 28918000 00000000
shrZ 8014 0 0 00000104 00000000
shrLow 22800 40918000 0 09234567 00000000
rolIr 1200 0 0 40918000 00000000
rolZ 8014 0 0 00000104 00000000
rolLow 22800 38918000 0 23456789 00000000
rorIr 1200 0 0 38918000 00000000
rorZ 8014 0 0 00000104 00000000
rorLow 22800 80918000 0 89234567 00000000
negIr 1200 0 0 80918000 00000000
negZ 8014 0 0 00000104 00000000
negLow 22800 88918000 0 FFFFFEFC 00000000
notIr 1200 0 0 88918000 00000000
notZ 8014 0 0 00000104 00000000
notLow 22800 70918000 0 FFFFFEFB 00000000
mulIr 1200 0 0 70918000 00000000
mulZ 8014 0 0 00000104 00000000
mulLow 22800 580BFFF0 0 7D27D1E0 00000000
mulHigh 10000 0 0 FFFFFF90 00000000
iNegIr 3A00 0000BEEF 0 580BFFF0 00000000
cNeg 400000 0 0 FFFFFFF0 00000000
r0Load 3809 58092345 0 0000BEEF 00000000
r0Read 11 0 0 0000BEEF 00000000
r0Base 31 0 0 00000000 00000000
r1Base 32 0 0 5A5A1234 00000000
iPosIr 1200 0 0 58092345 00000000
cPos 400000 0 0 00012345 00000000
pcInc 1000100 0 C0FFEE11 00000000 00000000
pcRead 2000080 0 0 00000041 00000000
inRead 2800000 0 0 C0FFEE11 00000041
outCheck 0 0 0 00000000 C0FFEE11

// File: tbChecker.sv
`timescale 1ns/1ns

module tbChecker (
	input logic clock,
	input logic checkValid,
	input logic [127:0] stepName,
	input logic [31:0] expBus,
	input logic [31:0] expOut,
	input logic marIn,
	input logic [31:0] busValue,
	input logic [31:0] outPortData,
	input logic [31:0] marValue,
	output int errorCount,
	output int stepCount
);

	// MAR clears at reset and loads the bus value of a step that raises marIn
	logic [31:0] expMar = '0;

	initial begin
		errorCount = 0;
		stepCount = 0;
	end

	always @(posedge clock) begin
		if (checkValid && marIn) begin
			expMar <= expBus;
		end
	end

	// inputs change just after the rising edge, so the falling edge sees settled values
	always @(negedge clock) begin
		if (checkValid) begin
			stepCount++;
			if (busValue !== expBus) begin
				errorCount++;
				$display("Error %0s: busValue expected %h, actual %h",
					stepName, expBus, busValue);
			end
			if (outPortData !== expOut) begin
				errorCount++;
				$display("Error %0s: outPortData expected %h, actual %h",
					stepName, expOut, outPortData);
			end
			if (marValue !== expMar) begin
				errorCount++;
				$display("Error %0s: marValue expected %h, actual %h",
					stepName, expMar, marValue);
			end
		end
	end

endmodule

// File: tbDataPath.sv
`timescale 1ns/1ns

module tbDataPath;

	localparam logic [31:0] resetPc = 32'h0000_0040;
	localparam int maxLines = 200;

	logic clock;
	logic rstN;
	// bit order follows the strobe column of the stimulus file
	logic [25:0] strobes;
	logic [31:0] memDataIn;
	logic [31:0] inPortData;
	logic [31:0] busValue;
	logic [31:0] outPortData;
	logic [31:0] marValue;

	logic checkValid;
	logic [127:0] stepName;
	logic [31:0] expBus;
	logic [31:0] expOut;
	int errorCount;
	int stepCount;

	dataPath #(
		.resetPc(resetPc)
	) dut (
		.clock(clock), .rstN(rstN),
		.gra(strobes[0]), .grb(strobes[1]), .grc(strobes[2]),
		.rIn(strobes[3]), .rOut(strobes[4]), .baOut(strobes[5]),
		.pcIn(strobes[6]), .pcOut(strobes[7]), .incPc(strobes[8]),
		.irIn(strobes[9]), .marIn(strobes[10]), .mdrIn(strobes[11]),
		.mdrOut(strobes[12]), .mdRead(strobes[13]), .yIn(strobes[14]),
		.zIn(strobes[15]), .zHighOut(strobes[16]), .zLowOut(strobes[17]),
		.hiIn(strobes[18]), .hiOut(strobes[19]), .loIn(strobes[20]),
		.loOut(strobes[21]), .cOut(strobes[22]), .inPortOut(strobes[23]),
		.strobe(strobes[24]), .outPortIn(strobes[25]),
		.memDataIn(memDataIn), .inPortData(inPortData),
		.busValue(busValue), .outPortData(outPortData), .marValue(marValue)
	);

	tbChecker checkUnit (
		.clock(clock), .checkValid(checkValid), .stepName(stepName),
		.expBus(expBus), .expOut(expOut), .marIn(strobes[10]),
		.busValue(busValue), .outPortData(outPortData), .marValue(marValue),
		.errorCount(errorCount), .stepCount(stepCount)
	);

	always #50 clock = ~clock;

	initial begin
		int fd;
		int code;
		int resetCycles;
		int linesRead;
		logic aborted;
		logic [31:0] mask;
		string line;
		clock = 1'b0;
		rstN = 1'b0;
		strobes = '0;
		memDataIn = '0;
		inPortData = '0;
		checkValid = 1'b0;
		stepName = '0;
		expBus = '0;
		expOut = '0;
		aborted = 1'b0;
		linesRead = 0;
		fd = $fopen("stepsInput.dat", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file stepsInput.dat");
			aborted = 1'b1;
		end
		resetCycles = 0;
		while (resetCycles < 4) begin
			@(posedge clock);
			resetCycles++;
		end
		#5;
		rstN = 1'b1;
		// one microstep per data line, applied 5 ns after the edge
		while (fd != 0 && !aborted && !$feof(fd)) begin
			if (linesRead >= maxLines) begin
				$display("line limit reached before the end of the stimulus file");
				aborted = 1'b1;
			end else begin
				code = $fgets(line, fd);
				linesRead++;
				if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
					code = $sscanf(line, "%s %h %h %h %h %h", stepName, mask,
						memDataIn, inPortData, expBus, expOut);
					if (code == 6) begin
						strobes = mask[25:0];
						checkValid = 1'b1;
						@(posedge clock);
						#5;
					end else begin
						$display("stimulus line %0d could not be parsed", linesRead);
						aborted = 1'b1;
					end
				end
			end
		end
		strobes = '0;
		checkValid = 1'b0;
		@(posedge clock);
		$display("%0d errors in %0d steps", errorCount, stepCount);
		if (aborted || errorCount != 0 || stepCount == 0) begin
			$display(">>> FAIL");
		end else begin
			$display(">>> PASS");
		end
		$finish;
	end

endmodule
